// File: design/gpio_pkg.sv
package gpio_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // number of gpio pins
  localparam int gpio_w = 16;

  // bus data width that pins are zero-extended into
  localparam int bus_dw = 32;

  // byte address width
  localparam int bus_aw = 8;

  ////////////////////////////////////////////////////////////////////////////
  // register map in byte offsets
  ////////////////////////////////////////////////////////////////////////////

  // output data
  localparam logic [7:0] reg_out = 8'h00;
  // output enable
  localparam logic [7:0] reg_oe = 8'h04;
  // synchronized pin input that is read only
  localparam logic [7:0] reg_in = 8'h08;
  // interrupt enable per pin
  localparam logic [7:0] reg_irq_en = 8'h0C;
  // sticky interrupt status cleared by writing ones
  localparam logic [7:0] reg_irq_stat = 8'h10;
  // edge polarity where 1 is rising and 0 falling
  localparam logic [7:0] reg_edge_sel = 8'h14;

  ////////////////////////////////////////////////////////////////////////////
  // bus types
  ////////////////////////////////////////////////////////////////////////////

  // request qualified by a separate req_vld strobe
  typedef struct packed {
    logic              wen;
    logic [bus_aw-1:0] adr;
    logic [bus_dw-1:0] wdt;
  } bus_req_t;

  // read response one cycle after the strobe
  typedef struct packed {
    logic              rvld;
    logic [bus_dw-1:0] rdt;
  } bus_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // register block to interrupt logic
  ////////////////////////////////////////////////////////////////////////////

  // clr_mask only lives in the cycle of the write strobe
  typedef struct packed {
    logic [gpio_w-1:0] clr_mask;
    logic [gpio_w-1:0] en;
  } irq_ctl_t;

endpackage

// File: design/gpio_sync.sv
`timescale 1ns/100ps

module gpio_sync import gpio_pkg::*; (
  input  logic              bus,
  input  logic              rst_n,
  // raw pins, asynchronous to bus
  input  logic [gpio_w-1:0] pin_in,
  // per pin polarity, 1 rising
  input  logic [gpio_w-1:0] edge_sel,
  output logic [gpio_w-1:0] in_sync,
  output logic [gpio_w-1:0] edge_evt
);

  ////////////////////////////////////////////////////////////////////////////
  // synchronizer and history
  ////////////////////////////////////////////////////////////////////////////

  // first stage, may go metastable
  logic [gpio_w-1:0] meta_q;
  // second stage, safe to use
  logic [gpio_w-1:0] sync_q;
  // one cycle older than sync_q
  logic [gpio_w-1:0] prev_q;

  // all three stages cleared, so a pin high out of reset
  // gives a single rising event once it arrives
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      meta_q <= '0;
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      meta_q <= pin_in;
      sync_q <= meta_q;
      prev_q <= sync_q;
    end
  end

  assign in_sync = sync_q;

  ////////////////////////////////////////////////////////////////////////////
  // edge detect
  ////////////////////////////////////////////////////////////////////////////

  logic [gpio_w-1:0] rise;
  logic [gpio_w-1:0] fall;

  // low to high
  assign rise = sync_q & ~prev_q;
  // high to low
  assign fall = ~sync_q & prev_q;

  // pick polarity per bit
  // event is combinational, lands in status next edge
  assign edge_evt = (edge_sel & rise) | (~edge_sel & fall);

endmodule

// File: design/gpio_regs.sv
`timescale 1ns/100ps

module gpio_regs import gpio_pkg::*; (
  input  logic              bus,
  input  logic              rst_n,
  // bus side
  input  logic              req_vld,
  input  bus_req_t          req,
  output bus_rsp_t          rsp,
  // pin side
  input  logic [gpio_w-1:0] in_sync,
  input  logic [gpio_w-1:0] status,
  output logic [gpio_w-1:0] pin_out,
  output logic [gpio_w-1:0] pin_oe,
  output logic [gpio_w-1:0] edge_sel,
  // to interrupt logic
  output irq_ctl_t          irq_ctl
);

  ////////////////////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////////////////////

  logic wr_en;
  logic rd_en;

  // every strobe is accepted, no back-pressure
  assign wr_en = req_vld & req.wen;
  assign rd_en = req_vld & ~req.wen;

  // address hits, full offset compare
  logic hit_out;
  logic hit_oe;
  logic hit_in;
  logic hit_irq_en;
  logic hit_irq_stat;
  logic hit_edge_sel;

  assign hit_out      = (req.adr == reg_out);
  assign hit_oe       = (req.adr == reg_oe);
  assign hit_in       = (req.adr == reg_in);
  assign hit_irq_en   = (req.adr == reg_irq_en);
  assign hit_irq_stat = (req.adr == reg_irq_stat);
  assign hit_edge_sel = (req.adr == reg_edge_sel);

  // only the low pins of the write word are kept
  logic [gpio_w-1:0] wr_pins;

  assign wr_pins = req.wdt[gpio_w-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // control registers
  ////////////////////////////////////////////////////////////////////////////

  logic [gpio_w-1:0] out_q;
  logic [gpio_w-1:0] oe_q;
  logic [gpio_w-1:0] irq_en_q;
  logic [gpio_w-1:0] edge_sel_q;

  // new value on the edge that samples the strobe
  // reg_in and unmapped offsets fall through untouched
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      out_q      <= '0;
      oe_q       <= '0;
      irq_en_q   <= '0;
      edge_sel_q <= '0;
    end else if (wr_en) begin
      if (hit_out) begin
        out_q <= wr_pins;
      end
      if (hit_oe) begin
        oe_q <= wr_pins;
      end
      if (hit_irq_en) begin
        irq_en_q <= wr_pins;
      end
      if (hit_edge_sel) begin
        edge_sel_q <= wr_pins;
      end
    end
  end

  assign pin_out  = out_q;
  assign pin_oe   = oe_q;
  assign edge_sel = edge_sel_q;

  // write one to clear, only during the strobe cycle
  // so the status drops on the same edge as other writes
  logic [gpio_w-1:0] clr_mask;

  assign clr_mask = (wr_en && hit_irq_stat) ? wr_pins : '0;

  assign irq_ctl = '{clr_mask: clr_mask, en: irq_en_q};

  ////////////////////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////////////////////

  logic [gpio_w-1:0] rd_sel;

  // unmapped offsets read zero
  always_comb begin
    rd_sel = '0;
    if (hit_out) begin
      rd_sel = out_q;
    end else if (hit_oe) begin
      rd_sel = oe_q;
    end else if (hit_in) begin
      rd_sel = in_sync;
    end else if (hit_irq_en) begin
      rd_sel = irq_en_q;
    end else if (hit_irq_stat) begin
      rd_sel = status;
    end else if (hit_edge_sel) begin
      rd_sel = edge_sel_q;
    end
  end

  logic              rvld_q;
  logic [bus_dw-1:0] rdt_q;

  // response strobe, one cycle after a read
  always_ff @(posedge bus) begin
    if (!rst_n) begin
      rvld_q <= 1'b0;
    end else begin
      rvld_q <= rd_en;
    end
  end

  // data only matters while rvld is high
  always_ff @(posedge bus) begin
    if (rd_en) begin
      rdt_q <= {{(bus_dw-gpio_w){1'b0}}, rd_sel};
    end
  end

  assign rsp = '{rvld: rvld_q, rdt: rdt_q};

endmodule

// File: design/gpio_irq.sv
`timescale 1ns/100ps

module gpio_irq import gpio_pkg::*; (
  input  logic              bus,
  input  logic              rst_n,
  // one cycle pulse per detected edge
  input  logic [gpio_w-1:0] edge_evt,
  // clear mask and enable from the register block
  input  irq_ctl_t          irq_ctl,
  output logic [gpio_w-1:0] status,
  output logic              irq
);

  ////////////////////////////////////////////////////////////////////////////
  // sticky status
  ////////////////////////////////////////////////////////////////////////////

  logic [gpio_w-1:0] stat_q;
  logic [gpio_w-1:0] stat_d;

  // set wins over clear
  // an edge in the clear cycle is never lost
  assign stat_d = (stat_q & ~irq_ctl.clr_mask) | edge_evt;

  always_ff @(posedge bus) begin
    if (!rst_n) begin
      stat_q <= '0;
    end else begin
      stat_q <= stat_d;
    end
  end

  assign status = stat_q;

  ////////////////////////////////////////////////////////////////////////////
  // interrupt line
  ////////////////////////////////////////////////////////////////////////////

  logic [gpio_w-1:0] pend;

  // status bits that are allowed through
  assign pend = stat_q & irq_ctl.en;

  // level output, both inputs already registered
  // so no extra lag behind the status
  assign irq = |pend;

endmodule

// File: design/gpio_top.sv
`timescale 1ns/100ps

module gpio_top import gpio_pkg::*; (
  input  logic              bus,
  input  logic              rst_n,
  // bus
  input  logic              req_vld,
  input  bus_req_t          req,
  output bus_rsp_t          rsp,
  // pins
  input  logic [gpio_w-1:0] pin_in,
  output logic [gpio_w-1:0] pin_out,
  output logic [gpio_w-1:0] pin_oe,
  // level interrupt
  output logic              irq
);

  ////////////////////////////////////////////////////////////////////////////
  // internal nets
  ////////////////////////////////////////////////////////////////////////////

  logic [gpio_w-1:0] in_sync;
  logic [gpio_w-1:0] edge_evt;
  logic [gpio_w-1:0] edge_sel;
  logic [gpio_w-1:0] status;
  irq_ctl_t          irq_ctl;

  // input synchronizer and edge detect
  gpio_sync u_sync (
    .bus      (bus),
    .rst_n    (rst_n),
    .pin_in   (pin_in),
    .edge_sel (edge_sel),
    .in_sync  (in_sync),
    .edge_evt (edge_evt)
  );

  // bus decode and registers
  gpio_regs u_regs (
    .bus      (bus),
    .rst_n    (rst_n),
    .req_vld  (req_vld),
    .req      (req),
    .rsp      (rsp),
    .in_sync  (in_sync),
    .status   (status),
    .pin_out  (pin_out),
    .pin_oe   (pin_oe),
    .edge_sel (edge_sel),
    .irq_ctl  (irq_ctl)
  );

  // status and interrupt line
  gpio_irq u_irq (
    .bus      (bus),
    .rst_n    (rst_n),
    .edge_evt (edge_evt),
    .irq_ctl  (irq_ctl),
    .status   (status),
    .irq      (irq)
  );

endmodule

// File: testbench/gpio_assert.sv
`timescale 1ns/100ps

module gpio_assert_chk import gpio_pkg::*; (
  input logic              bus,
  input logic              rst_n,
  input logic              req_vld,
  input bus_req_t          req,
  input bus_rsp_t          rsp,
  input logic [gpio_w-1:0] pin_out,
  input logic [gpio_w-1:0] pin_oe,
  input logic              irq,
  // internal nets of gpio_top
  input logic [gpio_w-1:0] status,
  input logic [gpio_w-1:0] edge_evt,
  input irq_ctl_t          irq_ctl
);

  // failures seen so far, read by the testbench
  int fail_cnt;

  initial begin
    fail_cnt = 0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // request qualifiers
  ////////////////////////////////////////////////////////////////////////////

  logic              rd_req;
  logic              wr_out;
  logic              wr_oe;
  logic              clr_all_en;
  logic [gpio_w-1:0] wr_pins;

  assign wr_pins = req.wdt[gpio_w-1:0];
  assign rd_req  = req_vld & ~req.wen;
  assign wr_out  = req_vld & req.wen & (req.adr == reg_out);
  assign wr_oe   = req_vld & req.wen & (req.adr == reg_oe);

  // clear write that leaves no enabled bit, with no enabled edge arriving
  assign clr_all_en = req_vld & req.wen & (req.adr == reg_irq_stat) & irq
                    & ((status & irq_ctl.en & ~wr_pins) == '0)
                    & ((edge_evt & irq_ctl.en) == '0);

  ////////////////////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////////////////////

  reset_quiet: assert property (@(posedge bus)
    !rst_n |=> (!irq && !rsp.rvld && pin_out == '0 && pin_oe == '0))
    else begin
      fail_cnt++;
      $error("outputs not cleared by reset");
    end

  // read answered exactly one cycle on
  rvld_after_read: assert property (@(posedge bus) disable iff (!rst_n)
    rd_req |=> rsp.rvld)
    else begin
      fail_cnt++;
      $error("rvld missing one cycle after a read strobe");
    end

  rvld_only_for_read: assert property (@(posedge bus) disable iff (!rst_n)
    !rd_req |=> !rsp.rvld)
    else begin
      fail_cnt++;
      $error("rvld without a read strobe one cycle before");
    end

  out_write_lands: assert property (@(posedge bus) disable iff (!rst_n)
    wr_out |=> pin_out == $past(wr_pins))
    else begin
      fail_cnt++;
      $error("pin_out did not take the written value");
    end

  oe_write_lands: assert property (@(posedge bus) disable iff (!rst_n)
    wr_oe |=> pin_oe == $past(wr_pins))
    else begin
      fail_cnt++;
      $error("pin_oe did not take the written value");
    end

  irq_clear_falls: assert property (@(posedge bus) disable iff (!rst_n)
    clr_all_en |=> !irq)
    else begin
      fail_cnt++;
      $error("irq still high after clearing all enabled status bits");
    end

endmodule

bind gpio_top gpio_assert_chk u_chk (
  .bus      (bus),
  .rst_n    (rst_n),
  .req_vld  (req_vld),
  .req      (req),
  .rsp      (rsp),
  .pin_out  (pin_out),
  .pin_oe   (pin_oe),
  .irq      (irq),
  .status   (status),
  .edge_evt (edge_evt),
  .irq_ctl  (irq_ctl)
);

// File: testbench/gpio_tb.sv
`timescale 1ns/100ps

module gpio_tb import gpio_pkg::*; ();

  ////////////////////////////////////////////////////////////////////////////
  // run length and dut signals
  ////////////////////////////////////////////////////////////////////////////

  localparam int clk_period = 4;
  localparam int n_rand = 24;
  // reset plus a generous per-round budget for every test
  localparam int test_cycles = 16 + n_rand * 48 + 100;

  logic              bus;
  logic              rst_n;
  logic              req_vld;
  bus_req_t          req;
  bus_rsp_t          rsp;
  logic [gpio_w-1:0] pin_in;
  logic [gpio_w-1:0] pin_out;
  logic [gpio_w-1:0] pin_oe;
  logic              irq;

  integer seed;
  int     err_cnt;

  // register model
  logic [gpio_w-1:0] out_m;
  logic [gpio_w-1:0] oe_m;
  logic [gpio_w-1:0] en_m;
  logic [gpio_w-1:0] sel_m;
  logic [gpio_w-1:0] stat_m;

  gpio_top u_gpio_top (
    .bus     (bus),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req     (req),
    .rsp     (rsp),
    .pin_in  (pin_in),
    .pin_out (pin_out),
    .pin_oe  (pin_oe),
    .irq     (irq)
  );

  always #(clk_period / 2) bus = ~bus;

  ////////////////////////////////////////////////////////////////////////////
  // bus and pin helpers, all driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge bus);
  endtask

  task automatic set_pins(input logic [gpio_w-1:0] v);
    @(negedge bus);
    pin_in = v;
  endtask

  // one strobe cycle, register updates on the edge in between
  task automatic write_reg(input logic [7:0] adr, input logic [bus_dw-1:0] data);
    @(negedge bus);
    req_vld = 1'b1;
    req.wen = 1'b1;
    req.adr = adr;
    req.wdt = data;
    @(negedge bus);
    req_vld = 1'b0;
  endtask

  // response expected one cycle on, a few more allowed before giving up
  task automatic read_reg(input logic [7:0] adr, output logic [bus_dw-1:0] data);
    int waited;
    waited = 0;
    @(negedge bus);
    req_vld = 1'b1;
    req.wen = 1'b0;
    req.adr = adr;
    req.wdt = '0;
    @(negedge bus);
    req_vld = 1'b0;
    while (!rsp.rvld && waited < 4) begin
      @(negedge bus);
      waited++;
    end
    if (!rsp.rvld) begin
      err_cnt++;
      $display("no read response for offset %h", adr);
    end
    data = rsp.rdt;
  endtask

  task automatic check_val(input string name, input logic [bus_dw-1:0] exp,
                           input logic [bus_dw-1:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic logic [bus_dw-1:0] widen(input logic [gpio_w-1:0] v);
    return {{(bus_dw-gpio_w){1'b0}}, v};
  endfunction

  // rising where sel is set, falling where it is clear
  function automatic logic [gpio_w-1:0] edges_seen(input logic [gpio_w-1:0] old_v,
                                                   input logic [gpio_w-1:0] new_v,
                                                   input logic [gpio_w-1:0] sel);
    return (sel & new_v & ~old_v) | (~sel & ~new_v & old_v);
  endfunction

  // random polarity, random pin change, then status and irq against the model
  task automatic edge_round(input logic clr_en_only);
    logic [bus_dw-1:0] rnd;
    logic [bus_dw-1:0] rd;
    logic [gpio_w-1:0] old_pins;
    rnd = $random(seed);
    sel_m = rnd[gpio_w-1:0];
    write_reg(reg_edge_sel, rnd);
    rnd = $random(seed);
    old_pins = pin_in;
    set_pins(rnd[gpio_w-1:0]);
    wait_cycles(4);
    stat_m = stat_m | edges_seen(old_pins, rnd[gpio_w-1:0], sel_m);
    read_reg(reg_irq_stat, rd);
    check_val("edge status", widen(stat_m), rd);
    check_val("irq level", {31'h0, |(stat_m & en_m)}, {31'h0, irq});
    // clearing only the enabled bits must drop irq on the next cycle
    if (clr_en_only) begin
      write_reg(reg_irq_stat, widen(en_m));
      stat_m = stat_m & ~en_m;
    end else begin
      write_reg(reg_irq_stat, 32'h0000ffff);
      stat_m = '0;
    end
    check_val("irq after clear", {31'h0, |(stat_m & en_m)}, {31'h0, irq});
  endtask

  // one closing line with the counts, then the verdict
  task automatic close_run(input logic timed_out);
    int assert_cnt;
    assert_cnt = u_gpio_top.u_chk.fail_cnt;
    $display("read errors %0d, assertion errors %0d", err_cnt, assert_cnt);
    if (timed_out || err_cnt != 0 || assert_cnt != 0) begin
      $display("Errors found");
    end else begin
      $display("No errors");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [bus_dw-1:0] rd;
    logic [bus_dw-1:0] rnd;
    seed = 32'ha37a;
    err_cnt = 0;
    bus = 1'b0;
    rst_n = 1'b0;
    req_vld = 1'b0;
    req = '0;
    pin_in = '0;
    out_m = '0;
    oe_m = '0;
    en_m = '0;
    sel_m = '0;
    stat_m = '0;
    repeat (16) @(negedge bus);
    rst_n = 1'b1;

    // reset values
    read_reg(reg_out, rd);
    check_val("reset out", 32'h0, rd);
    read_reg(reg_oe, rd);
    check_val("reset oe", 32'h0, rd);
    read_reg(reg_irq_stat, rd);
    check_val("reset status", 32'h0, rd);
    check_val("reset irq", 32'h0, {31'h0, irq});

    // out and oe, upper write bits dropped
    for (int i = 0; i < n_rand; i++) begin
      rnd = $random(seed);
      out_m = rnd[gpio_w-1:0];
      write_reg(reg_out, rnd);
      check_val("pin_out", widen(out_m), widen(pin_out));
      rnd = $random(seed);
      oe_m = rnd[gpio_w-1:0];
      write_reg(reg_oe, rnd);
      check_val("pin_oe", widen(oe_m), widen(pin_oe));
      read_reg(reg_out, rd);
      check_val("out readback", widen(out_m), rd);
      read_reg(reg_oe, rd);
      check_val("oe readback", widen(oe_m), rd);
    end

    // synchronized input, held three cycles
    for (int i = 0; i < n_rand; i++) begin
      rnd = $random(seed);
      set_pins(rnd[gpio_w-1:0]);
      wait_cycles(3);
      read_reg(reg_in, rd);
      check_val("in readback", widen(pin_in), rd);
    end
    // reg_in and unmapped offsets ignore writes and read zero where unmapped
    write_reg(reg_in, 32'h0000a5a5);
    write_reg(8'h18, 32'h0000ffff);
    read_reg(reg_in, rd);
    check_val("in after write", widen(pin_in), rd);
    read_reg(reg_out, rd);
    check_val("out after unmapped write", widen(out_m), rd);
    read_reg(8'h18, rd);
    check_val("unmapped 0x18", 32'h0, rd);
    read_reg(8'h02, rd);
    check_val("unmapped 0x02", 32'h0, rd);
    read_reg(8'hfc, rd);
    check_val("unmapped 0xfc", 32'h0, rd);

    // flush events left from the input test
    wait_cycles(4);
    write_reg(reg_irq_stat, 32'h0000ffff);
    stat_m = '0;

    // edge polarity, interrupts masked
    for (int i = 0; i < n_rand; i++) begin
      edge_round(1'b0);
    end

    // interrupt line with a random enable
    rnd = $random(seed);
    en_m = rnd[gpio_w-1:0] | 16'h0001;
    write_reg(reg_irq_en, widen(en_m));
    read_reg(reg_irq_en, rd);
    check_val("irq enable readback", widen(en_m), rd);
    for (int i = 0; i < n_rand; i++) begin
      rnd = $random(seed);
      edge_round(rnd[0]);
    end

    wait_cycles(2);
    close_run(1'b0);
  end

  // watchdog, twice the budgeted run
  initial begin
    #(2 * test_cycles * clk_period);
    $display("watchdog expired after %0d cycles, tests did not finish", 2 * test_cycles);
    close_run(1'b1);
  end

endmodule

// File: flist.f
design/gpio_pkg.sv
design/gpio_sync.sv
design/gpio_regs.sv
design/gpio_irq.sv
design/gpio_top.sv
testbench/gpio_assert.sv
testbench/gpio_tb.sv

// File: run.sh
#!/bin/sh
# build and run the gpio testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module gpio_tb -f flist.f

# the simulation may stop early on an assertion, the log decides
./obj_dir/Vgpio_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^No errors$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
